//--- bench/ps2_keyboard_rx_tb.sv
/*
  PS/2 keyboard receiver testbench
  Sends LFSR-picked key codes as keyboard frames, reads every event
  back through the data-ready handshake, the checker compares
*/

`timescale 1ns/10ps

`include "ps2_defines.svh"

module ps2_keyboard_rx_tb;

  localparam int clk_period = 100;  // ns
  localparam int half_bit   = 25;   // Clk cycles per ps2_clk half period
  localparam int max_frames = 160;  // Upper bound over all tests
  localparam int frame_ns   = `PS2_FRAME_BITS * 2 * half_bit * clk_period;
  localparam int timeout_ns = max_frames * frame_ns * 2;

  logic                clk = 1'b0;
  logic                reset;
  logic                ps2_clk;
  logic                ps2_data;
  logic                rx_read;
  logic                test_end;
  logic                rx_extended;
  logic                rx_released;
  ps2_pkg::scan_code_t rx_scan_code;
  ps2_pkg::ascii_t     rx_ascii;
  logic                rx_data_ready;
  logic                rx_shift_key_on;
  logic                caps_lock;
  int                  event_count;
  int                  error_count;
  logic [31:0]         lfsr_state;
  int                  events_before;
  int                  errors_before;
  int                  n;
  int                  k;
  int                  pick;
  ps2_pkg::scan_code_t shift_code;

  // Letters, digits, symbols, control keys and one unlisted code (F1)
  ps2_pkg::scan_code_t plain_keys [16] = '{8'h1c, 8'h32, 8'h21, 8'h24, 8'h1a, 8'h4d,
                                           8'h16, 8'h1e, 8'h46, 8'h41, 8'h4e, 8'h29,
                                           8'h5a, 8'h66, 8'h05, 8'h0e};
  // Keys whose value changes with shift or caps lock
  ps2_pkg::scan_code_t mixed_keys [8] = '{8'h1c, 8'h32, 8'h21, 8'h24,
                                          8'h1a, 8'h4d, 8'h16, 8'h41};

  ps2_keyboard_rx #(
    .trap_shift_keys (0)
  ) ps2_keyboard_rx_inst (
    .clk             (clk),
    .reset           (reset),
    .ps2_clk         (ps2_clk),
    .ps2_data        (ps2_data),
    .rx_read         (rx_read),
    .rx_extended     (rx_extended),
    .rx_released     (rx_released),
    .rx_scan_code    (rx_scan_code),
    .rx_ascii        (rx_ascii),
    .rx_data_ready   (rx_data_ready),
    .rx_shift_key_on (rx_shift_key_on),
    .caps_lock       (caps_lock)
  );

  ps2_rx_checker ps2_rx_checker_inst (
    .clk             (clk),
    .reset           (reset),
    .ps2_clk         (ps2_clk),
    .ps2_data        (ps2_data),
    .rx_read         (rx_read),
    .rx_extended     (rx_extended),
    .rx_released     (rx_released),
    .rx_scan_code    (rx_scan_code),
    .rx_ascii        (rx_ascii),
    .rx_data_ready   (rx_data_ready),
    .rx_shift_key_on (rx_shift_key_on),
    .caps_lock       (caps_lock),
    .test_end        (test_end),
    .event_count     (event_count),
    .error_count     (error_count)
  );

  initial
  begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // ----------------------------------------
  // Random source and keyboard driver
  // ----------------------------------------

  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
  endfunction

  task take_bits(input int count, output int value);
    int i;
    value = 0;
    for (i = 0; i < count; i++)
    begin
      lfsr_state = lfsr_step(lfsr_state);
      value = (value << 1) | lfsr_state[0];
    end
  endtask

  // Called on a falling clk edge, bit 0 goes first
  task send_bits(input logic [10:0] frame, input int count);
    int i;
    for (i = 0; i < count; i++)
    begin
      ps2_data = frame[i];
      repeat (half_bit) @(negedge clk);
      ps2_clk = 1'b0;                 // Receiver samples on this fall
      repeat (half_bit) @(negedge clk);
      ps2_clk = 1'b1;
    end
    ps2_data = 1'b1;
  endtask

  task read_event();
    int wait_cycles;
    int hold;
    wait_cycles = 0;
    while (!rx_data_ready && (wait_cycles < 200))
    begin
      @(negedge clk);
      wait_cycles++;
    end
    if (rx_data_ready)
    begin
      take_bits(4, hold);
      repeat (hold) @(negedge clk);   // Ready must stay up meanwhile
      rx_read = 1'b1;
      @(negedge clk);
      rx_read = 1'b0;
      wait_cycles = 0;
      while (rx_data_ready && (wait_cycles < 10))
      begin
        @(negedge clk);
        wait_cycles++;
      end
    end
  endtask

  task send_key(input ps2_pkg::scan_code_t code);
    int gap;
    send_bits({1'b1, ~^code, code, 1'b0}, 11);  // Odd parity
    if ((code != `PS2_CODE_EXTEND) && (code != `PS2_CODE_RELEASE))
      read_event();
    take_bits(6, gap);
    repeat (gap + 4) @(negedge clk);
  endtask

  task send_plain();
    int idx;
    take_bits(4, idx);
    send_key(plain_keys[idx]);
  endtask

  task send_mixed();
    int idx;
    take_bits(3, idx);
    send_key(mixed_keys[idx]);
  endtask

  task close_test(input int number, input string name);
    @(negedge clk);
    test_end = 1'b1;
    @(negedge clk);
    test_end = 1'b0;
    $display("Test %0d, %s: %0d events, %0d errors", number, name,
             event_count - events_before, error_count - errors_before);
    events_before = event_count;
    errors_before = error_count;
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------

  initial
  begin
    reset         = 1'b1;
    ps2_clk       = 1'b1;         // Idle bus
    ps2_data      = 1'b1;
    rx_read       = 1'b0;
    test_end      = 1'b0;
    lfsr_state    = 32'h71333ae0;
    events_before = 0;
    errors_before = 0;
    repeat (8) @(negedge clk);
    reset = 1'b0;
    repeat (4) @(negedge clk);

    for (n = 0; n < 12; n++)
      send_plain();
    close_test(1, "plain keys");

    for (n = 0; n < 8; n++)
    begin
      take_bits(2, pick);
      if ((pick == 0) || (pick == 2)) send_key(`PS2_CODE_EXTEND);
      if ((pick == 1) || (pick == 2)) send_key(`PS2_CODE_RELEASE);
      send_plain();                   // Carries the flags
      send_plain();                   // Flags cleared again
    end
    close_test(2, "prefix codes");

    for (n = 0; n < 2; n++)
    begin
      take_bits(1, pick);
      shift_code = pick ? `PS2_CODE_RSHIFT : `PS2_CODE_LSHIFT;
      send_key(shift_code);
      for (k = 0; k < 4; k++)
        send_mixed();
      send_key(`PS2_CODE_RELEASE);
      send_key(shift_code);
      for (k = 0; k < 2; k++)
        send_mixed();
    end
    close_test(3, "shift keys");

    send_key(`PS2_CODE_CAPS);
    send_key(`PS2_CODE_RELEASE);
    send_key(`PS2_CODE_CAPS);         // Break leaves caps lock alone
    for (k = 0; k < 3; k++)
      send_mixed();
    send_key(`PS2_CODE_CTRL);
    send_key(8'h21);                  // Ctrl-C
    send_key(`PS2_CODE_RELEASE);
    send_key(`PS2_CODE_CTRL);
    send_key(8'h21);
    send_key(`PS2_CODE_LSHIFT);       // Shift with caps still upper case
    send_mixed();
    send_key(`PS2_CODE_RELEASE);
    send_key(`PS2_CODE_LSHIFT);
    send_key(`PS2_CODE_CAPS);
    send_key(`PS2_CODE_RELEASE);
    send_key(`PS2_CODE_CAPS);
    for (k = 0; k < 3; k++)
      send_mixed();
    close_test(4, "caps lock and ctrl");

    for (n = 0; n < 2; n++)
    begin
      take_bits(8, pick);
      send_bits({2'b10, pick[7:0], 1'b0}, 4);  // Start bit and 3 data bits
      repeat (2 * `PS2_WATCHDOG_CYCLES) @(negedge clk);
      send_plain();
      send_plain();
    end
    close_test(5, "partial frame");

    $display("Summary: %0d events checked, %0d errors", event_count, error_count);
    if (error_count == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

  // Watchdog
  initial
  begin
    #(timeout_ns);
    $display("Run stopped after %0d ns before the tests were done", timeout_ns);
    $display("TEST FAILED");
    $finish;
  end

endmodule

//--- bench/ps2_rx_checker.sv
/*
  PS/2 receive checker
  Decodes keyboard frames from the bus pins, keeps a reference model
  of the prefixes and modifier keys and compares every output update
  and the data-ready handshake of the DUT with it
*/

`timescale 1ns/10ps

`include "ps2_defines.svh"

module ps2_rx_checker (
  input  logic                clk,
  input  logic                reset,
  input  logic                ps2_clk,
  input  logic                ps2_data,
  input  logic                rx_read,
  input  logic                rx_extended,
  input  logic                rx_released,
  input  ps2_pkg::scan_code_t rx_scan_code,
  input  ps2_pkg::ascii_t     rx_ascii,
  input  logic                rx_data_ready,
  input  logic                rx_shift_key_on,
  input  logic                caps_lock,
  input  logic                test_end,     // Events still owed are missing
  output int                  event_count,
  output int                  error_count
);

  typedef struct packed {
    logic                extended;
    logic                released;
    ps2_pkg::scan_code_t code;
    ps2_pkg::ascii_t     ascii;
  } key_event_t;

  key_event_t      expected_q[$];    // Events the DUT still owes
  logic [10:0]     frame_bits;
  int              bit_num;
  int              idle_cycles;      // Clk cycles with ps2_clk high
  logic            hold_ext;
  logic            hold_rel;
  logic            lshift;
  logic            rshift;
  logic            ctrl;
  logic            caps;
  logic            prev_reset;
  logic            prev_ready;
  logic            prev_read;
  int              events;
  int              errors;

  assign event_count = events;
  assign error_count = errors;

  // Part of the UK layout table that the stimulus uses
  function automatic ps2_pkg::ascii_t expected_ascii(input ps2_pkg::scan_code_t code,
                                                     input logic shift, input logic caps_on,
                                                     input logic ctrl_on);
    ps2_pkg::ascii_t lower;
    lower = 7'h00;
    case (code)
      8'h1c: lower = 7'h61;  // a
      8'h32: lower = 7'h62;  // b
      8'h21: lower = 7'h63;  // c
      8'h24: lower = 7'h65;  // e
      8'h1a: lower = 7'h7a;  // z
      8'h4d: lower = 7'h70;  // p
      default: lower = 7'h00;
    endcase
    if (lower != 7'h00)
    begin
      if ((code == 8'h21) && ctrl_on)
        return 7'h03;
      return (shift || caps_on) ? lower - 7'h20 : lower;
    end
    case (code)
      8'h16: return shift ? 7'h21 : 7'h31;  // 1 !
      8'h1e: return shift ? 7'h22 : 7'h32;  // 2 "
      8'h46: return shift ? 7'h28 : 7'h39;  // 9 (
      8'h41: return shift ? 7'h3c : 7'h2c;  // , <
      8'h4e: return shift ? 7'h5f : 7'h2d;  // - _
      8'h0e: return shift ? 7'h7c : 7'h60;
      8'h29: return 7'h20;                  // Space
      8'h5a: return 7'h0d;                  // Enter
      8'h66: return 7'h08;                  // Backspace
      default: return 7'h00;
    endcase
  endfunction

  task check_value(input string name, input logic [31:0] got, input logic [31:0] expected);
    if (got !== expected)
    begin
      $display("ERROR %0t ns: %s is %0h, expected %0h", $time, name, got, expected);
      errors++;
    end
  endtask

  // ----------------------------------------
  // Reference model
  // ----------------------------------------

  task apply_code(input ps2_pkg::scan_code_t code);
    key_event_t ev;
    if (code == `PS2_CODE_EXTEND)
      hold_ext = 1'b1;
    else if (code == `PS2_CODE_RELEASE)
      hold_rel = 1'b1;
    else
    begin
      if (expected_q.size() != 0)
      begin
        $display("Missing event: key code %h gave no output before the next code, at %0t ns",
                 expected_q[0].code, $time);
        errors++;
        expected_q.delete();
      end
      ev.extended = hold_ext;
      ev.released = hold_rel;
      ev.code     = code;
      ev.ascii    = expected_ascii(code, lshift || rshift, caps, ctrl);  // Old modifiers
      expected_q.push_back(ev);
      if (code == `PS2_CODE_LSHIFT) lshift = !hold_rel;
      if (code == `PS2_CODE_RSHIFT) rshift = !hold_rel;
      if (code == `PS2_CODE_CTRL) ctrl = !hold_rel;
      if ((code == `PS2_CODE_CAPS) && !hold_rel)
        caps = !caps;                 // Make code toggles
      hold_ext = 1'b0;
      hold_rel = 1'b0;
    end
  endtask

  // Frame decoder on the keyboard clock
  always @(negedge ps2_clk)
  begin
    if (!reset)
    begin
      if (idle_cycles >= `PS2_WATCHDOG_CYCLES)
        bit_num = 0;                  // Stale partial frame is dropped
      frame_bits[bit_num] = ps2_data;
      bit_num++;
      if (bit_num == `PS2_FRAME_BITS)
      begin
        bit_num = 0;
        apply_code(frame_bits[8:1]);
      end
    end
  end

  // ----------------------------------------
  // Output comparison
  // ----------------------------------------

  task compare_event();
    key_event_t ev;
    if (expected_q.size() == 0)
    begin
      $display("Unexpected event: data ready rose with no key code sent, at %0t ns", $time);
      errors++;
    end
    else
    begin
      ev = expected_q.pop_front();
      check_value("rx_scan_code", rx_scan_code, ev.code);
      check_value("rx_ascii", rx_ascii, ev.ascii);
      check_value("rx_extended", rx_extended, ev.extended);
      check_value("rx_released", rx_released, ev.released);
      check_value("rx_shift_key_on", rx_shift_key_on, lshift || rshift);
      check_value("caps_lock", caps_lock, caps);
      events++;
    end
  endtask

  // Samples before the DUT registers update on this edge
  always @(posedge clk)
  begin
    if (reset)
    begin
      expected_q.delete();
      bit_num     = 0;
      idle_cycles = 0;
      hold_ext    = 1'b0;
      hold_rel    = 1'b0;
      lshift      = 1'b0;
      rshift      = 1'b0;
      ctrl        = 1'b0;
      caps        = 1'b0;
      events      = 0;
      errors      = 0;
    end
    else
    begin
      if (prev_reset)
      begin
        check_value("rx_data_ready after reset", rx_data_ready, 0);
        check_value("rx_scan_code after reset", rx_scan_code, 0);
        check_value("rx_ascii after reset", rx_ascii, 0);
        check_value("rx_extended after reset", rx_extended, 0);
        check_value("rx_released after reset", rx_released, 0);
        check_value("caps_lock after reset", caps_lock, 0);
        check_value("rx_shift_key_on after reset", rx_shift_key_on, 0);
      end
      if (!ps2_clk)
        idle_cycles = 0;
      else if (idle_cycles < 4 * `PS2_WATCHDOG_CYCLES)
        idle_cycles++;
      if (test_end && (expected_q.size() != 0))
      begin
        $display("Missing event: key code %h never raised data ready, at %0t ns",
                 expected_q[0].code, $time);
        errors++;
        expected_q.delete();
      end
      if (rx_data_ready && !prev_ready)
        compare_event();
      if (prev_ready && !prev_read && !rx_data_ready)
      begin
        $display("ERROR %0t ns: rx_data_ready fell without rx_read", $time);
        errors++;
      end
      if (prev_ready && prev_read && rx_data_ready)
      begin
        $display("ERROR %0t ns: rx_data_ready still high after rx_read", $time);
        errors++;
      end
    end
    prev_reset = reset;
    prev_ready = rx_data_ready;
    prev_read  = rx_read;
  end

endmodule

//--- files.f
+incdir+logic
logic/ps2_pkg.sv
logic/key_event_if.sv
logic/ps2_rx_frame.sv
logic/scan_to_ascii.sv
logic/key_state_tracker.sv
logic/rx_output_port.sv
logic/ps2_keyboard_rx.sv
bench/ps2_rx_checker.sv
bench/ps2_keyboard_rx_tb.sv

//--- logic/key_event_if.sv
/*
  Key event bus
  One decoded key event from the tracker to the output registers,
  valid only in the cycle that strobe is high
*/

`timescale 1ns/10ps

interface key_event_if;

  logic                 strobe;     // Single-cycle event pulse
  logic                 extended;   // E0 came before this code
  logic                 released;   // F0 came before this code
  ps2_pkg::scan_code_t  scan_code;  // Key code itself
  ps2_pkg::ascii_t      ascii;      // Translated character, 0 if none

  // Tracker side
  modport src (
    output strobe,
    output extended,
    output released,
    output scan_code,
    output ascii
  );

  // Output register side, no back-pressure
  modport dst (
    input strobe,
    input extended,
    input released,
    input scan_code,
    input ascii
  );

endinterface

//--- logic/key_state_tracker.sv
/*
  Key state tracker
  Holds the E0/F0 prefixes, follows shift, ctrl and caps lock,
  and issues one key event per real key code
*/

`timescale 1ns/10ps

`include "ps2_defines.svh"

module key_state_tracker #(
  parameter int trap_shift_keys = 0  // 1 hides shift codes from the output
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                code_valid,
  input  ps2_pkg::scan_code_t code,
  key_event_if.src            event_out,
  output logic                shift_key_on,
  output logic                caps_lock
);

  logic            is_extend;       // Current code is E0
  logic            is_release;      // Current code is F0
  logic            is_shift;        // Either shift key
  logic            key_code;        // Complete non-prefix code
  logic            hold_extended;   // E0 seen, waiting for the key
  logic            hold_released;   // F0 seen, waiting for the key
  logic            left_shift;
  logic            right_shift;
  logic            ctrl_key;
  ps2_pkg::ascii_t ascii;

  assign is_extend  = (code == `PS2_CODE_EXTEND);
  assign is_release = (code == `PS2_CODE_RELEASE);
  assign is_shift   = (code == `PS2_CODE_LSHIFT) || (code == `PS2_CODE_RSHIFT);
  assign key_code   = code_valid && !is_extend && !is_release;

  // ----------------------------------------
  // Prefix holding
  // ----------------------------------------

  // Cleared by any real code, even a trapped shift
  always_ff @(posedge clk)
  begin
    if (reset || key_code)
    begin
      hold_extended <= 1'b0;
      hold_released <= 1'b0;
    end
    else if (code_valid)
    begin
      if (is_extend) hold_extended <= 1'b1;
      if (is_release) hold_released <= 1'b1;
    end
  end

  // ----------------------------------------
  // Modifier keys
  // ----------------------------------------

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      left_shift  <= 1'b0;
      right_shift <= 1'b0;
      ctrl_key    <= 1'b0;
      caps_lock   <= 1'b0;
    end
    else if (code_valid)
    begin
      // Make sets, break clears
      if (code == `PS2_CODE_LSHIFT) left_shift  <= !hold_released;
      if (code == `PS2_CODE_RSHIFT) right_shift <= !hold_released;
      if (code == `PS2_CODE_CTRL)   ctrl_key    <= !hold_released;
      if ((code == `PS2_CODE_CAPS) && !hold_released)
        caps_lock <= !caps_lock;  // Toggle on make only
    end
  end

  assign shift_key_on = left_shift || right_shift;

  // Translation sees the modifiers as they were before this code
  scan_to_ascii scan_to_ascii_inst (
    .code     (code),
    .shift_on (shift_key_on),
    .caps_on  (caps_lock),
    .ctrl_on  (ctrl_key),
    .ascii    (ascii)
  );

  // ----------------------------------------
  // Event output
  // ----------------------------------------

  assign event_out.strobe    = key_code && ((trap_shift_keys == 0) || !is_shift);
  assign event_out.extended  = hold_extended;
  assign event_out.released  = hold_released;
  assign event_out.scan_code = code;
  assign event_out.ascii     = ascii;

endmodule

//--- logic/ps2_defines.svh
/*
  PS/2 keyboard receiver constants
  Frame length, receive watchdog limit and the special scan codes
  that the key tracker reacts to
*/

`ifndef PS2_DEFINES_SVH
`define PS2_DEFINES_SVH

// ----------------------------------------
// Frame and watchdog
// ----------------------------------------

// Start, 8 data bits, parity, stop
`define PS2_FRAME_BITS       11

// Roughly 60 us of silence at about 49 MHz
`define PS2_WATCHDOG_CYCLES  2950
`define PS2_WATCHDOG_BITS    12    // Holds PS2_WATCHDOG_CYCLES-1

// ----------------------------------------
// Scan codes with special meaning
// ----------------------------------------

`define PS2_CODE_EXTEND      8'hE0  // Extended key prefix
`define PS2_CODE_RELEASE     8'hF0  // Break prefix
`define PS2_CODE_LSHIFT      8'h12  // Left shift
`define PS2_CODE_RSHIFT      8'h59  // Right shift
`define PS2_CODE_CTRL        8'h14  // Ctrl, left and right share it
`define PS2_CODE_CAPS        8'h58  // Caps lock

`endif

//--- logic/ps2_keyboard_rx.sv
/*
  PS/2 keyboard receiver, top level
  Frame receiver, key tracker and output port
*/

`timescale 1ns/10ps

module ps2_keyboard_rx #(
  parameter int trap_shift_keys = 0  // 1 hides shift codes from the output
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                ps2_clk,
  input  logic                ps2_data,
  input  logic                rx_read,        // Host acknowledge
  output logic                rx_extended,
  output logic                rx_released,
  output ps2_pkg::scan_code_t rx_scan_code,
  output ps2_pkg::ascii_t     rx_ascii,
  output logic                rx_data_ready,
  output logic                rx_shift_key_on,
  output logic                caps_lock
);

  logic                code_valid;  // Frame complete
  ps2_pkg::scan_code_t code;

  key_event_if event_bus ();       // Tracker to output port

  ps2_rx_frame ps2_rx_frame_inst (
    .clk        (clk),
    .reset      (reset),
    .ps2_clk    (ps2_clk),
    .ps2_data   (ps2_data),
    .code_valid (code_valid),
    .code       (code)
  );

  key_state_tracker #(
    .trap_shift_keys (trap_shift_keys)
  ) key_state_tracker_inst (
    .clk          (clk),
    .reset        (reset),
    .code_valid   (code_valid),
    .code         (code),
    .event_out    (event_bus.src),
    .shift_key_on (rx_shift_key_on),
    .caps_lock    (caps_lock)
  );

  rx_output_port rx_output_port_inst (
    .clk           (clk),
    .reset         (reset),
    .event_in      (event_bus.dst),
    .rx_read       (rx_read),
    .rx_extended   (rx_extended),
    .rx_released   (rx_released),
    .rx_scan_code  (rx_scan_code),
    .rx_ascii      (rx_ascii),
    .rx_data_ready (rx_data_ready)
  );

endmodule

//--- logic/ps2_pkg.sv
/*
  PS/2 keyboard receiver types
  Vector types for codes, frames and counters, plus the state
  encodings of the receive and data-ready machines
*/

`include "ps2_defines.svh"

package ps2_pkg;

  // ----------------------------------------
  // Data widths
  // ----------------------------------------

  typedef logic [7:0] scan_code_t;   // One byte from the keyboard
  typedef logic [6:0] ascii_t;       // 7-bit character

  // Whole frame as it sits in the shift register
  typedef logic [`PS2_FRAME_BITS-1:0] frame_t;

  typedef logic [3:0] bit_count_t;   // Counts up to 11 bits

  // Idle timer of the receiver
  typedef logic [`PS2_WATCHDOG_BITS-1:0] watchdog_count_t;

  // ----------------------------------------
  // State machines
  // ----------------------------------------

  // Follows the level of the keyboard clock line
  typedef enum logic [1:0] {
    rx_clk_h,        // Line high, waiting for fall
    rx_fall_marker,  // One cycle after a fall, samples data
    rx_clk_l,        // Line low, waiting for rise
    rx_rise_marker   // One cycle after a rise
  } rx_state_e;

  // Data-ready handshake toward the host
  typedef enum logic {
    ready_idle,      // Nothing pending
    ready_full       // Output holds an unread event
  } ready_state_e;

endpackage

//--- logic/ps2_rx_frame.sv
/*
  PS/2 frame receiver
  Synchronizes the keyboard lines, follows the clock edges, shifts
  in 11-bit frames and flags each complete byte. An idle watchdog
  throws away a partly received frame.
*/

`timescale 1ns/10ps

`include "ps2_defines.svh"

module ps2_rx_frame (
  input  logic                clk,
  input  logic                reset,
  input  logic                ps2_clk,
  input  logic                ps2_data,
  output logic                code_valid,  // One cycle per complete frame
  output ps2_pkg::scan_code_t code         // Data byte of the frame
);

  logic                       ps2_clk_m;   // First stage, may go metastable
  logic                       ps2_data_m;
  logic                       ps2_clk_s;   // Clock line in clk domain
  logic                       ps2_data_s;  // Data line in clk domain
  ps2_pkg::rx_state_e         state;
  ps2_pkg::rx_state_e         next_state;
  ps2_pkg::frame_t            shift_q;
  ps2_pkg::bit_count_t        bit_count;
  ps2_pkg::watchdog_count_t   watchdog_count;
  logic                       watchdog_run;
  logic                       watchdog_done;

  // ----------------------------------------
  // Input synchronizers
  // ----------------------------------------

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      ps2_clk_m  <= 1'b1;  // Idle lines are pulled high
      ps2_data_m <= 1'b1;
      ps2_clk_s  <= 1'b1;
      ps2_data_s <= 1'b1;
    end
    else
    begin
      ps2_clk_m  <= ps2_clk;
      ps2_data_m <= ps2_data;
      ps2_clk_s  <= ps2_clk_m;
      ps2_data_s <= ps2_data_m;
    end
  end

  // ----------------------------------------
  // Edge following FSM
  // ----------------------------------------

  always_ff @(posedge clk)
  begin
    if (reset)
      state <= ps2_pkg::rx_clk_h;
    else
      state <= next_state;
  end

  always_comb
  begin
    next_state = state;
    case (state)
      ps2_pkg::rx_clk_h:
        if (!ps2_clk_s) next_state = ps2_pkg::rx_fall_marker;
      ps2_pkg::rx_fall_marker:
        next_state = ps2_pkg::rx_clk_l;  // Single marker cycle
      ps2_pkg::rx_clk_l:
        if (ps2_clk_s) next_state = ps2_pkg::rx_rise_marker;
      ps2_pkg::rx_rise_marker:
        next_state = ps2_pkg::rx_clk_h;
      default:
        next_state = ps2_pkg::rx_clk_h;
    endcase
  end

  // Watchdog only runs while the line sits at a level
  assign watchdog_run = (state == ps2_pkg::rx_clk_h) || (state == ps2_pkg::rx_clk_l);

  // ----------------------------------------
  // Shift register and bit counter
  // ----------------------------------------

  // Keyboard sends LSB first, so shift in from the top
  always_ff @(posedge clk)
  begin
    if (state == ps2_pkg::rx_fall_marker)
      shift_q <= {ps2_data_s, shift_q[`PS2_FRAME_BITS-1:1]};
  end

  always_ff @(posedge clk)
  begin
    if (reset || code_valid)
      bit_count <= '0;  // Frame done, start over
    else if (watchdog_done && (state == ps2_pkg::rx_clk_h) && ps2_clk_s)
      bit_count <= '0;  // Line quiet too long, drop partial frame
    else if (state == ps2_pkg::rx_fall_marker)
      bit_count <= bit_count + 1'b1;
  end

  assign code_valid = (bit_count == ps2_pkg::bit_count_t'(`PS2_FRAME_BITS));
  assign code       = shift_q[8:1];  // Skip start bit, drop parity and stop

  // ----------------------------------------
  // Idle watchdog
  // ----------------------------------------

  always_ff @(posedge clk)
  begin
    if (reset || !watchdog_run)
      watchdog_count <= '0;  // Restarts at every edge marker
    else if (!watchdog_done)
      watchdog_count <= watchdog_count + 1'b1;  // Saturates at the limit
  end

  assign watchdog_done =
    (watchdog_count == ps2_pkg::watchdog_count_t'(`PS2_WATCHDOG_CYCLES - 1));

endmodule

//--- logic/rx_output_port.sv
/*
  Receive output port
  Latches each key event and raises data ready until the host
  acknowledges it with rx_read
*/

`timescale 1ns/10ps

module rx_output_port (
  input  logic                clk,
  input  logic                reset,
  key_event_if.dst            event_in,
  input  logic                rx_read,
  output logic                rx_extended,
  output logic                rx_released,
  output ps2_pkg::scan_code_t rx_scan_code,
  output ps2_pkg::ascii_t     rx_ascii,
  output logic                rx_data_ready
);

  ps2_pkg::ready_state_e state;
  ps2_pkg::ready_state_e next_state;

  // ----------------------------------------
  // Output registers
  // ----------------------------------------

  // A new event overwrites even unread data
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      rx_extended  <= 1'b0;
      rx_released  <= 1'b0;
      rx_scan_code <= '0;
      rx_ascii     <= '0;
    end
    else if (event_in.strobe)
    begin
      rx_extended  <= event_in.extended;
      rx_released  <= event_in.released;
      rx_scan_code <= event_in.scan_code;
      rx_ascii     <= event_in.ascii;
    end
  end

  // ----------------------------------------
  // Data-ready handshake
  // ----------------------------------------

  always_ff @(posedge clk)
  begin
    if (reset)
      state <= ps2_pkg::ready_idle;
    else
      state <= next_state;
  end

  always_comb
  begin
    next_state = state;
    if (event_in.strobe)
      next_state = ps2_pkg::ready_full;  // Fresh data wins over a read
    else if ((state == ps2_pkg::ready_full) && rx_read)
      next_state = ps2_pkg::ready_idle;
  end

  assign rx_data_ready = (state == ps2_pkg::ready_full);

endmodule

//--- logic/scan_to_ascii.sv
/*
  Scan code to ASCII table
  Set 2 codes to 7-bit characters. Shift or caps lock give upper
  case letters, shift picks the second symbol, ctrl-C gives 03.
*/

`timescale 1ns/10ps

module scan_to_ascii (
  input  ps2_pkg::scan_code_t code,
  input  logic                shift_on,
  input  logic                caps_on,
  input  logic                ctrl_on,
  output ps2_pkg::ascii_t     ascii
);

  logic            is_letter;  // Code is one of A..Z
  ps2_pkg::ascii_t lower;      // Lower case form of the letter

  always_comb
  begin
    is_letter = 1'b1;
    lower     = 7'h00;
    ascii     = 7'h00;  // Unlisted codes

    // ----------------------------------------
    // Letters
    // ----------------------------------------
    case (code)
      8'h1c: lower = 7'h61;  // a
      8'h32: lower = 7'h62;  // b
      8'h21: lower = 7'h63;  // c
      8'h23: lower = 7'h64;  // d
      8'h24: lower = 7'h65;  // e
      8'h2b: lower = 7'h66;  // f
      8'h34: lower = 7'h67;  // g
      8'h33: lower = 7'h68;  // h
      8'h43: lower = 7'h69;  // i
      8'h3b: lower = 7'h6a;  // j
      8'h42: lower = 7'h6b;  // k
      8'h4b: lower = 7'h6c;  // l
      8'h3a: lower = 7'h6d;  // m
      8'h31: lower = 7'h6e;  // n
      8'h44: lower = 7'h6f;  // o
      8'h4d: lower = 7'h70;  // p
      8'h15: lower = 7'h71;  // q
      8'h2d: lower = 7'h72;  // r
      8'h1b: lower = 7'h73;  // s
      8'h2c: lower = 7'h74;  // t
      8'h3c: lower = 7'h75;  // u
      8'h2a: lower = 7'h76;  // v
      8'h1d: lower = 7'h77;  // w
      8'h22: lower = 7'h78;  // x
      8'h35: lower = 7'h79;  // y
      8'h1a: lower = 7'h7a;  // z
      default: is_letter = 1'b0;
    endcase

    if (is_letter)
    begin
      // Shift and caps both force upper case, no cancelling
      ascii = (shift_on || caps_on) ? (lower & 7'h5f) : lower;
      if ((code == 8'h21) && ctrl_on)
        ascii = 7'h03;  // Ctrl-C
    end
    else
    begin
      // ----------------------------------------
      // Control keys, digits and symbols
      // ----------------------------------------
      casez ({shift_on, code})
        9'h?66: ascii = 7'h08;  // Backspace
        9'h?0d: ascii = 7'h09;  // Tab
        9'h?5a: ascii = 7'h0d;  // Enter
        9'h?76: ascii = 7'h1b;  // Esc
        9'h?29: ascii = 7'h20;  // Space
        9'h?71: ascii = 7'h7f;  // Delete, also keypad
        // Unshifted
        9'h016: ascii = 7'h31;  // 1
        9'h01e: ascii = 7'h32;  // 2
        9'h026: ascii = 7'h33;  // 3
        9'h025: ascii = 7'h34;  // 4
        9'h02e: ascii = 7'h35;  // 5
        9'h036: ascii = 7'h36;  // 6
        9'h03d: ascii = 7'h37;  // 7
        9'h03e: ascii = 7'h38;  // 8
        9'h046: ascii = 7'h39;  // 9
        9'h045: ascii = 7'h30;  // 0
        9'h05d: ascii = 7'h23;  // #
        9'h052: ascii = 7'h27;  // '
        9'h041: ascii = 7'h2c;  // ,
        9'h04e: ascii = 7'h2d;  // -
        9'h049: ascii = 7'h2e;  // .
        9'h04a: ascii = 7'h2f;  // /
        9'h04c: ascii = 7'h3b;  // ;
        9'h055: ascii = 7'h3d;  // =
        9'h054: ascii = 7'h5b;  // [
        9'h05b: ascii = 7'h5d;  // ]
        9'h00e: ascii = 7'h60;  // Backtick
        9'h061: ascii = 7'h5c;  // Backslash, extra key left of Z
        // Shifted, UK layout
        9'h116: ascii = 7'h21;  // !
        9'h11e: ascii = 7'h22;  // Double quote
        9'h126: ascii = 7'h5c;  // Backslash
        9'h125: ascii = 7'h24;  // $
        9'h12e: ascii = 7'h25;  // %
        9'h136: ascii = 7'h5e;  // ^
        9'h13d: ascii = 7'h26;  // &
        9'h13e: ascii = 7'h2a;  // *
        9'h146: ascii = 7'h28;  // (
        9'h145: ascii = 7'h29;  // )
        9'h15d: ascii = 7'h7e;  // ~
        9'h152: ascii = 7'h40;  // @
        9'h141: ascii = 7'h3c;  // <
        9'h14e: ascii = 7'h5f;  // _
        9'h149: ascii = 7'h3e;  // >
        9'h14a: ascii = 7'h3f;  // ?
        9'h14c: ascii = 7'h3a;  // :
        9'h155: ascii = 7'h2b;  // +
        9'h154: ascii = 7'h7b;  // {
        9'h15b: ascii = 7'h7d;  // }
        9'h10e: ascii = 7'h7c;  // |
        default: ascii = 7'h00;
      endcase
    end
  end

endmodule
